/* Makefile */
# Verilator flow for the digit classifier testbench

VERILATOR  ?= verilator
TOP        ?= digit_classifier_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only -Wall --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FAIL_MSG   ?= TEST RESULT: FAIL
PASS_MSG   ?= TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(TIMESCALE) -f $(FILELIST) --top-module $(TOP) \
	  --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/digit_classifier_checker.sv */
`include "digit_consts.svh"

module digit_classifier_checker (
  input logic               clk,
  input logic               rst_n,
  input digit_pkg::status_t status,
  input digit_pkg::seg_t    seg,
  input logic               heartbeat,
  input logic               class_start,
  input logic               buffer_full
);
  timeunit 1ns;
  timeprecision 1ps;

  // ==================================================
  // Display and control properties
  // ==================================================
  // One cycle of lag allowed when leaving DONE
  assert property (@(posedge clk) disable iff (!rst_n)
    (status != `STATUS_DONE && $past(status) != `STATUS_DONE) |-> seg == `SEG_BLANK)
    else $error("seg shows %h while status is %h", seg, status);

  // Start fires once, in the first cycle the buffer is full
  assert property (@(posedge clk) disable iff (!rst_n)
    class_start == $rose(buffer_full))
    else $error("class_start out of step with the image buffer filling");

  // First cycle out of reset has no valid history
  assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> heartbeat != $past(heartbeat))
    else $error("heartbeat stopped toggling");

endmodule

/* bench/digit_classifier_tb.sv */
`include "digit_consts.svh"

module digit_classifier_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // ==================================================
  // Frame timing and run limit
  // ==================================================
  localparam int HALF_CYCLES    = 5;   // SCLK half period in clk cycles
  localparam int BYTE_CYCLES    = 8 * 2 * HALF_CYCLES;
  localparam int FRAME_GAP      = 5 * HALF_CYCLES;
  localparam int FRAME_CYCLES   = (`IMG_BYTES + 1) * BYTE_CYCLES + FRAME_GAP;
  localparam int NUM_FRAMES     = 14;
  localparam int WAIT_CYCLES    = 40;  // Classification plus pipeline slack
  localparam int TIMEOUT_CYCLES = NUM_FRAMES * (FRAME_CYCLES + WAIT_CYCLES) + 200;

  logic               clk;
  logic               rst_n;
  logic               sclk;
  logic               copi;
  logic               cs_n;
  digit_pkg::status_t status;
  digit_pkg::seg_t    seg;
  logic               heartbeat;

  int          error_count;
  int          check_count;
  int          cycle_count;
  logic [31:0] lfsr_state;

  digit_pkg::image_t weight_table [`NUM_CLASSES] = '{
    `WEIGHT_0, `WEIGHT_1, `WEIGHT_2, `WEIGHT_3, `WEIGHT_4,
    `WEIGHT_5, `WEIGHT_6, `WEIGHT_7, `WEIGHT_8, `WEIGHT_9
  };

  digit_classifier_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .sclk      (sclk),
    .copi      (copi),
    .cs_n      (cs_n),
    .status    (status),
    .seg       (seg),
    .heartbeat (heartbeat)
  );

  bind digit_classifier_top digit_classifier_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .status      (status),
    .seg         (seg),
    .heartbeat   (heartbeat),
    .class_start (class_start),
    .buffer_full (buffer_full)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d clock cycles", cycle_count);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
  endfunction

  task automatic make_random_image(output digit_pkg::image_t im);
    for (int i = 0; i < `IMG_BITS; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      im[i]      = lfsr_state[0];
    end
  endtask

  // Most matching pixels wins, first class kept on a tie
  function automatic digit_pkg::class_t ref_class(input digit_pkg::image_t im);
    digit_pkg::class_t best;
    digit_pkg::score_t best_score;
    digit_pkg::score_t sc;
    best       = '0;
    best_score = '0;
    for (int c = 0; c < `NUM_CLASSES; c++) begin
      sc = digit_pkg::score_t'($countones(~(im ^ weight_table[c])));
      if (c == 0 || sc > best_score) begin
        best       = digit_pkg::class_t'(c);
        best_score = sc;
      end
    end
    return best;
  endfunction

  function automatic digit_pkg::seg_t seg_of_digit(input digit_pkg::class_t d);
    case (d)
      4'd0:    return 7'h40;
      4'd1:    return 7'h79;
      4'd2:    return 7'h24;
      4'd3:    return 7'h30;
      4'd4:    return 7'h19;
      4'd5:    return 7'h12;
      4'd6:    return 7'h02;
      4'd7:    return 7'h78;
      4'd8:    return 7'h00;
      4'd9:    return 7'h10;
      default: return `SEG_BLANK;
    endcase
  endfunction

  // ==================================================
  // Compare tasks
  // ==================================================
  task automatic check_status(input digit_pkg::status_t got, input digit_pkg::status_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED status: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_seg(input digit_pkg::seg_t got, input digit_pkg::seg_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED seg: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_heartbeat(input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED heartbeat: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic wait_for_status(input digit_pkg::status_t want);
    int n;
    n = 0;
    while (status !== want && n < WAIT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (status !== want) begin
      error_count++;
      $display("Status never reached %h within %0d cycles", want, WAIT_CYCLES);
    end
  endtask

  // ==================================================
  // SPI mode 0 driver
  // ==================================================
  task automatic begin_frame();
    cs_n = 1'b0;
    repeat (HALF_CYCLES) @(negedge clk);
  endtask

  task automatic send_byte(input digit_pkg::spi_byte_t b);
    for (int i = 7; i >= 0; i--) begin
      copi = b[i];   // Set up while SCLK is low
      sclk = 1'b0;
      repeat (HALF_CYCLES) @(negedge clk);
      sclk = 1'b1;
      repeat (HALF_CYCLES) @(negedge clk);
    end
  endtask

  task automatic end_frame();
    sclk = 1'b0;
    repeat (HALF_CYCLES) @(negedge clk);
    cs_n = 1'b1;
    repeat (3 * HALF_CYCLES) @(negedge clk);
  endtask

  task automatic send_command(input digit_pkg::spi_byte_t cmd);
    begin_frame();
    send_byte(cmd);
    end_frame();
  endtask

  // ==================================================
  // Directed tests
  // ==================================================
  task automatic test_reset_state();
    logic exp_hb;
    exp_hb = 1'b1;   // One rising edge since reset release
    check_status(status, `STATUS_IDLE);
    check_seg(seg, `SEG_BLANK);
    for (int i = 0; i < 4; i++) begin
      check_heartbeat(heartbeat, exp_hb);
      @(negedge clk);
      exp_hb = ~exp_hb;
    end
  endtask

  task automatic load_and_check(input digit_pkg::image_t im);
    digit_pkg::class_t exp_class;
    exp_class = ref_class(im);
    begin_frame();
    send_byte(`CMD_LOAD);
    for (int k = 0; k < `IMG_BYTES; k++) send_byte(im[8*k +: 8]);   // Byte 0 first
    end_frame();
    wait_for_status(`STATUS_DONE);
    check_status(status, `STATUS_DONE);
    check_seg(seg, seg_of_digit(exp_class));
  endtask

  task automatic test_random_images();
    digit_pkg::image_t im;
    for (int n = 0; n < 6; n++) begin
      make_random_image(im);
      load_and_check(im);
    end
    load_and_check('0);
    load_and_check('1);
  endtask

  task automatic test_clear();
    send_command(`CMD_CLEAR);
    wait_for_status(`STATUS_IDLE);
    @(negedge clk);   // seg lags status by one cycle
    check_status(status, `STATUS_IDLE);
    check_seg(seg, `SEG_BLANK);
  endtask

  task automatic test_bad_command();
    send_command(8'h5A);
    wait_for_status(`STATUS_BAD_CMD);
    check_status(status, `STATUS_BAD_CMD);
    check_seg(seg, `SEG_BLANK);
    test_clear();
  endtask

  task automatic test_short_frame();
    digit_pkg::image_t im;
    make_random_image(im);
    begin_frame();
    send_byte(`CMD_LOAD);
    for (int k = 0; k < 3; k++) send_byte(im[8*k +: 8]);
    end_frame();
    wait_for_status(`STATUS_IDLE);
    check_status(status, `STATUS_IDLE);
    check_seg(seg, `SEG_BLANK);
    make_random_image(im);
    load_and_check(im);
  endtask

  initial begin
    digit_pkg::image_t first_img;
    rst_n       = 1'b0;
    sclk        = 1'b0;
    copi        = 1'b0;
    cs_n        = 1'b1;
    error_count = 0;
    check_count = 0;
    lfsr_state  = 32'h20e7;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    test_reset_state();
    make_random_image(first_img);
    load_and_check(first_img);
    test_random_images();
    test_clear();
    test_bad_command();
    test_short_frame();

    $display("Checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* design/bnn_classifier.sv */
`include "digit_consts.svh"

module bnn_classifier (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              class_start,
  input  logic              buf_clear,
  input  digit_pkg::image_t img,
  output digit_pkg::class_t result,
  output logic              result_ready
);

  // ==================================================
  // Weight lookup and XNOR popcount
  // ==================================================
  function automatic digit_pkg::image_t weight_of(input digit_pkg::class_t c);
    case (c)
      4'd0:    return `WEIGHT_0;
      4'd1:    return `WEIGHT_1;
      4'd2:    return `WEIGHT_2;
      4'd3:    return `WEIGHT_3;
      4'd4:    return `WEIGHT_4;
      4'd5:    return `WEIGHT_5;
      4'd6:    return `WEIGHT_6;
      4'd7:    return `WEIGHT_7;
      4'd8:    return `WEIGHT_8;
      4'd9:    return `WEIGHT_9;
      default: return '0;
    endcase
  endfunction

  function automatic digit_pkg::score_t match_count(input digit_pkg::image_t a,
                                                    input digit_pkg::image_t b);
    digit_pkg::score_t cnt;
    cnt = '0;
    for (int i = 0; i < `IMG_BITS; i++) begin
      cnt = cnt + digit_pkg::score_t'(a[i] ~^ b[i]);
    end
    return cnt;
  endfunction

  digit_pkg::image_t img_q;
  digit_pkg::class_t idx;
  digit_pkg::class_t best_class;
  digit_pkg::score_t best_score;
  digit_pkg::score_t score;
  digit_pkg::class_t win_class;
  logic              busy;

  assign score     = match_count(img_q, weight_of(idx));
  assign win_class = (score > best_score) ? idx : best_class;   // Ties keep the lower class

  always_ff @(posedge clk) begin
    if (class_start) img_q <= img;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy         <= 1'b0;
      idx          <= '0;
      best_score   <= '0;
      best_class   <= '0;
      result       <= '0;
      result_ready <= 1'b0;
    end else if (buf_clear) begin
      busy         <= 1'b0;
      result       <= '0;
      result_ready <= 1'b0;
    end else if (class_start) begin
      busy         <= 1'b1;
      idx          <= '0;
      best_score   <= '0;
      best_class   <= '0;
      result_ready <= 1'b0;
    end else if (busy) begin
      if (score > best_score) begin
        best_score <= score;
        best_class <= idx;
      end
      if (idx == `NUM_CLASSES - 1) begin
        busy         <= 1'b0;
        result       <= win_class;
        result_ready <= 1'b1;
      end else begin
        idx <= idx + 4'd1;
      end
    end
  end

endmodule

/* design/digit_classifier_top.sv */
module digit_classifier_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               sclk,
  input  logic               copi,
  input  logic               cs_n,
  output digit_pkg::status_t status,
  output digit_pkg::seg_t    seg,
  output logic               heartbeat
);

  // ==================================================
  // Interconnect
  // ==================================================
  digit_pkg::spi_byte_t rx_data;
  logic                 byte_valid;
  logic                 frame_start;
  logic                 frame_end;

  logic                 wr_en;
  logic                 buf_clear;
  logic                 class_start;
  digit_pkg::buf_addr_t wr_addr;
  digit_pkg::spi_byte_t wr_data;

  digit_pkg::image_t    img;
  logic                 buffer_full;

  digit_pkg::class_t    result;
  logic                 result_ready;

  spi_byte_receiver u_spi_byte_receiver (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .copi        (copi),
    .cs_n        (cs_n),
    .rx_data     (rx_data),
    .byte_valid  (byte_valid),
    .frame_start (frame_start),
    .frame_end   (frame_end)
  );

  frame_controller u_frame_controller (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_data      (rx_data),
    .byte_valid   (byte_valid),
    .frame_start  (frame_start),
    .frame_end    (frame_end),
    .buffer_full  (buffer_full),
    .result_ready (result_ready),
    .wr_en        (wr_en),
    .buf_clear    (buf_clear),
    .class_start  (class_start),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .status       (status)
  );

  image_buffer u_image_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .wr_en        (wr_en),
    .buf_clear    (buf_clear),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data),
    .img          (img),
    .buffer_full  (buffer_full),
    .buffer_empty ()
  );

  bnn_classifier u_bnn_classifier (
    .clk          (clk),
    .rst_n        (rst_n),
    .class_start  (class_start),
    .buf_clear    (buf_clear),
    .img          (img),
    .result       (result),
    .result_ready (result_ready)
  );

  result_display u_result_display (
    .clk          (clk),
    .rst_n        (rst_n),
    .result_ready (result_ready),
    .result       (result),
    .seg          (seg),
    .heartbeat    (heartbeat)
  );

endmodule

/* design/digit_consts.svh */
`ifndef DIGIT_CONSTS_SVH
`define DIGIT_CONSTS_SVH

// ==================================================
// Image geometry and class count
// ==================================================
`define IMG_BYTES    8
`define IMG_BITS     64
`define NUM_CLASSES  10

// Command bytes, first byte of every frame
`define CMD_LOAD     8'hA1
`define CMD_CLEAR    8'hC0

// Status codes on the status pins
`define STATUS_IDLE     4'h0
`define STATUS_LOADING  4'h1
`define STATUS_BUSY     4'h2
`define STATUS_DONE     4'h3
`define STATUS_BAD_CMD  4'hE

// All segments off, active low
`define SEG_BLANK    7'h7F

// ==================================================
// Binary weights, one 8x8 glyph per class
// ==================================================
// Row 0 sits in the low byte, bit 0 is the left pixel
`define WEIGHT_0  64'h003C_666E_7666_663C
`define WEIGHT_1  64'h007E_1818_1818_1C18
`define WEIGHT_2  64'h007E_0C18_3060_663C
`define WEIGHT_3  64'h003C_6660_3860_663C
`define WEIGHT_4  64'h0030_307E_3336_3C38
`define WEIGHT_5  64'h003C_6660_603E_067E
`define WEIGHT_6  64'h003C_6666_3E06_0C38
`define WEIGHT_7  64'h000C_0C0C_1830_607E
`define WEIGHT_8  64'h003C_6666_3C66_663C
`define WEIGHT_9  64'h001C_3060_7C66_663C

`endif

/* design/digit_pkg.sv */
package digit_pkg;

  // ==================================================
  // Vector types shared across the classifier
  // ==================================================
  typedef logic [7:0]  spi_byte_t;   // One SPI byte
  typedef logic [2:0]  buf_addr_t;   // Image byte address
  typedef logic [63:0] image_t;      // Byte 0 in the low bits
  typedef logic [3:0]  class_t;      // Digit 0 to 9
  typedef logic [6:0]  score_t;      // Popcount 0 to 64
  typedef logic [3:0]  status_t;
  typedef logic [6:0]  seg_t;        // Segments g..a, active low

  // Frame controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CMD,
    ST_LOAD,
    ST_RUN,
    ST_DONE,
    ST_ERR
  } ctrl_state_t;

endpackage

/* design/frame_controller.sv */
`include "digit_consts.svh"

module frame_controller (
  input  logic                 clk,
  input  logic                 rst_n,
  input  digit_pkg::spi_byte_t rx_data,
  input  logic                 byte_valid,
  input  logic                 frame_start,
  input  logic                 frame_end,
  input  logic                 buffer_full,
  input  logic                 result_ready,
  output logic                 wr_en,
  output logic                 buf_clear,
  output logic                 class_start,
  output digit_pkg::buf_addr_t wr_addr,
  output digit_pkg::spi_byte_t wr_data,
  output digit_pkg::status_t   status
);

  digit_pkg::ctrl_state_t state_q, state_d;
  logic [3:0]             load_cnt;   // Image bytes taken in this frame
  logic                   load_done;
  logic                   take_byte;

  assign load_done = (load_cnt == `IMG_BYTES);
  assign take_byte = (state_q == digit_pkg::ST_LOAD) && byte_valid && !load_done;

  // ==================================================
  // Next state and strobes
  // ==================================================
  always_comb begin
    state_d     = state_q;
    buf_clear   = 1'b0;
    class_start = 1'b0;
    case (state_q)
      digit_pkg::ST_IDLE, digit_pkg::ST_DONE, digit_pkg::ST_ERR: begin
        if (frame_start) state_d = digit_pkg::ST_CMD;
      end
      digit_pkg::ST_CMD: begin
        if (byte_valid) begin
          case (rx_data)
            `CMD_LOAD: begin
              buf_clear = 1'b1;   // Old image and result go away
              state_d   = digit_pkg::ST_LOAD;
            end
            `CMD_CLEAR: begin
              buf_clear = 1'b1;
              state_d   = digit_pkg::ST_IDLE;
            end
            default: state_d = digit_pkg::ST_ERR;
          endcase
        end else if (frame_end) begin
          state_d = digit_pkg::ST_IDLE;   // Empty frame
        end
      end
      digit_pkg::ST_LOAD: begin
        if (buffer_full) begin
          class_start = 1'b1;
          state_d     = digit_pkg::ST_RUN;
        end else if (frame_end && !load_done) begin
          buf_clear = 1'b1;   // Short frame, drop partial image
          state_d   = digit_pkg::ST_IDLE;
        end
      end
      digit_pkg::ST_RUN: begin
        if (result_ready) state_d = digit_pkg::ST_DONE;
      end
      default: state_d = digit_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= digit_pkg::ST_IDLE;
      status   <= `STATUS_IDLE;
      load_cnt <= '0;
      wr_en    <= 1'b0;
      wr_addr  <= '0;
    end else begin
      state_q <= state_d;
      wr_en   <= take_byte;   // Write lands one cycle after the strobe
      if (state_q == digit_pkg::ST_CMD) begin
        load_cnt <= '0;
      end else if (take_byte) begin
        load_cnt <= load_cnt + 4'd1;
        wr_addr  <= load_cnt[2:0];
      end
      case (state_d)
        digit_pkg::ST_IDLE: status <= `STATUS_IDLE;
        digit_pkg::ST_LOAD: status <= `STATUS_LOADING;
        digit_pkg::ST_RUN:  status <= `STATUS_BUSY;
        digit_pkg::ST_DONE: status <= `STATUS_DONE;
        digit_pkg::ST_ERR:  status <= `STATUS_BAD_CMD;
        default:            status <= status;   // Hold during command byte
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (take_byte) wr_data <= rx_data;
  end

endmodule

/* design/image_buffer.sv */
`include "digit_consts.svh"

module image_buffer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wr_en,
  input  logic                 buf_clear,
  input  digit_pkg::buf_addr_t wr_addr,
  input  digit_pkg::spi_byte_t wr_data,
  output digit_pkg::image_t    img,
  output logic                 buffer_full,
  output logic                 buffer_empty
);

  localparam int CNT_W = $clog2(`IMG_BYTES + 1);

  digit_pkg::spi_byte_t mem [`IMG_BYTES];
  logic [CNT_W-1:0]     count_q, count_d;

  // Byte storage, cleared on command
  always_ff @(posedge clk) begin
    if (buf_clear) begin
      for (int i = 0; i < `IMG_BYTES; i++) mem[i] <= '0;
    end else if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  always_comb begin
    for (int i = 0; i < `IMG_BYTES; i++) img[8*i +: 8] = mem[i];
  end

  always_comb begin
    count_d = count_q;
    if (buf_clear) count_d = '0;
    else if (wr_en && count_q != CNT_W'(`IMG_BYTES)) count_d = count_q + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count_q      <= '0;
      buffer_full  <= 1'b0;
      buffer_empty <= 1'b1;
    end else begin
      count_q      <= count_d;
      buffer_full  <= (count_d == CNT_W'(`IMG_BYTES));
      buffer_empty <= (count_d == '0);
    end
  end

endmodule

/* design/result_display.sv */
`include "digit_consts.svh"

module result_display (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              result_ready,
  input  digit_pkg::class_t result,
  output digit_pkg::seg_t   seg,
  output logic              heartbeat
);

  digit_pkg::seg_t seg_next;

  // Active-low patterns, bit 6 is segment g
  always_comb begin
    if (!result_ready) begin
      seg_next = `SEG_BLANK;
    end else begin
      case (result)
        4'd0:    seg_next = 7'b100_0000;
        4'd1:    seg_next = 7'b111_1001;
        4'd2:    seg_next = 7'b010_0100;
        4'd3:    seg_next = 7'b011_0000;
        4'd4:    seg_next = 7'b001_1001;
        4'd5:    seg_next = 7'b001_0010;
        4'd6:    seg_next = 7'b000_0010;
        4'd7:    seg_next = 7'b111_1000;
        4'd8:    seg_next = 7'b000_0000;
        4'd9:    seg_next = 7'b001_0000;
        default: seg_next = `SEG_BLANK;   // Out of range
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      seg       <= `SEG_BLANK;
      heartbeat <= 1'b0;
    end else begin
      seg       <= seg_next;
      heartbeat <= ~heartbeat;   // Alive indicator
    end
  end

endmodule

/* design/spi_byte_receiver.sv */
module spi_byte_receiver (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 sclk,
  input  logic                 copi,
  input  logic                 cs_n,
  output digit_pkg::spi_byte_t rx_data,
  output logic                 byte_valid,
  output logic                 frame_start,
  output logic                 frame_end
);

  // Two-flop synchronizers plus one history stage for edges
  logic [2:0] sclk_sync;
  logic [1:0] copi_sync;
  logic [2:0] cs_sync;

  logic       sclk_rise;
  logic [6:0] shift_q;   // First seven bits of the byte
  logic [2:0] bit_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync <= '0;
      copi_sync <= '0;
      cs_sync   <= 3'b111;   // Deselected at reset
    end else begin
      sclk_sync <= {sclk_sync[1:0], sclk};
      copi_sync <= {copi_sync[0], copi};
      cs_sync   <= {cs_sync[1:0], cs_n};
    end
  end

  assign sclk_rise   = sclk_sync[1] & ~sclk_sync[2] & ~cs_sync[1];
  assign frame_start = ~cs_sync[1] & cs_sync[2];
  assign frame_end   = cs_sync[1] & ~cs_sync[2];

  // ==================================================
  // Bit shifter, MSB first
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      if (frame_start) begin
        bit_cnt <= '0;
      end else if (sclk_rise) begin
        bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 after the 8th bit
        if (bit_cnt == 3'd7) byte_valid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sclk_rise) begin
      shift_q <= {shift_q[5:0], copi_sync[1]};
      if (bit_cnt == 3'd7) rx_data <= {shift_q, copi_sync[1]};
    end
  end

endmodule

/* files.f */
+incdir+design
design/digit_pkg.sv
design/spi_byte_receiver.sv
design/frame_controller.sv
design/image_buffer.sv
design/bnn_classifier.sv
design/result_display.sv
design/digit_classifier_top.sv
bench/digit_classifier_checker.sv
bench/digit_classifier_tb.sv
